/* logic/dds_pkg.sv */
package dds_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	typedef logic [31:0] phase_t;           // accumulator and increment
	typedef logic signed [11:0] sample_t;   // two's complement
	typedef logic [7:0] scan_event_t;       // bit 7 set on a break
	typedef logic [4:0] lfsr_t;

	// bits 7:0 keys 1 to 8, then space, n, m, left, right, up, down
	typedef logic [14:0] held_keys_t;

	typedef enum logic [1:0] {
		SINE,
		COSINE,
		SQUARE,
		SAW
	} wave_sel_e;

	typedef enum logic [1:0] {
		NONE,
		ASK,
		BPSK,
		FSK
	} mod_sel_e;

	typedef struct packed {
		sample_t sine;
		sample_t cosine;
		sample_t square;
		sample_t saw;
	} waves_t;

	typedef struct packed {
		logic        valid;  // one cycle strobe
		scan_event_t code;
	} key_event_t;

	// ps/2 set 2 make codes, arrows without the e0 prefix
	localparam scan_event_t SC_KEY_1 = 8'h16;
	localparam scan_event_t SC_KEY_2 = 8'h1E;
	localparam scan_event_t SC_KEY_3 = 8'h26;
	localparam scan_event_t SC_KEY_4 = 8'h25;
	localparam scan_event_t SC_KEY_5 = 8'h2E;
	localparam scan_event_t SC_KEY_6 = 8'h36;
	localparam scan_event_t SC_KEY_7 = 8'h3D;
	localparam scan_event_t SC_KEY_8 = 8'h3E;
	localparam scan_event_t SC_SPACE = 8'h29;
	localparam scan_event_t SC_N = 8'h31;
	localparam scan_event_t SC_M = 8'h3A;
	localparam scan_event_t SC_ARROW_LEFT = 8'h6B;
	localparam scan_event_t SC_ARROW_RIGHT = 8'h74;
	localparam scan_event_t SC_ARROW_UP = 8'h75;
	localparam scan_event_t SC_ARROW_DOWN = 8'h72;

	localparam lfsr_t LFSR_SEED = 5'd1;
	localparam lfsr_t LFSR_TAPS = 5'b10100;         // x^5 + x^3 + 1
	localparam phase_t DDS_CARRIER_INC = 32'd85899346; // about 500 khz at 25 mhz

	localparam sample_t SAMPLE_MAX = 12'sh7FF;
	localparam sample_t SAMPLE_MIN = 12'sh800;

	// first quarter wave, sampled at half-step offsets so the mirror is exact
	localparam logic [10:0] sine_quarter [64] = '{
		11'd25,   11'd75,   11'd126,  11'd176,  11'd226,  11'd275,  11'd325,  11'd375,
		11'd424,  11'd473,  11'd522,  11'd570,  11'd618,  11'd666,  11'd713,  11'd760,
		11'd807,  11'd852,  11'd898,  11'd943,  11'd987,  11'd1031, 11'd1074, 11'd1116,
		11'd1158, 11'd1199, 11'd1239, 11'd1279, 11'd1318, 11'd1356, 11'd1393, 11'd1430,
		11'd1465, 11'd1500, 11'd1533, 11'd1566, 11'd1598, 11'd1629, 11'd1659, 11'd1688,
		11'd1716, 11'd1743, 11'd1769, 11'd1793, 11'd1817, 11'd1840, 11'd1861, 11'd1881,
		11'd1901, 11'd1919, 11'd1936, 11'd1951, 11'd1966, 11'd1979, 11'd1992, 11'd2003,
		11'd2012, 11'd2021, 11'd2028, 11'd2035, 11'd2039, 11'd2043, 11'd2046, 11'd2047
	};

endpackage

/* logic/keying_bit_source.sv */
`timescale 1ns/100ps

module keying_bit_source
	import dds_pkg::*;
#(
	parameter int TICK_DIV = 25_000_000
)
(
	input  logic CLK_25MHZ,
	input  logic reset_from_key,
	output logic keying_bit
);

	localparam int CNT_W = ($clog2(TICK_DIV) > 0) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_count;
	logic             tick;
	lfsr_t            lfsr;
	logic             feedback;

	////////////////////////////////////////////////////////////
	// tick divider, a clock enable instead of a slow clock
	////////////////////////////////////////////////////////////
	assign tick = (div_count == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			div_count <= '0;
		else if (tick)
			div_count <= '0;
		else
			div_count <= div_count + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// fibonacci lfsr, one step per tick
	////////////////////////////////////////////////////////////
	assign feedback = ^(lfsr & LFSR_TAPS);

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			lfsr <= LFSR_SEED;
		else if (tick)
			lfsr <= {lfsr[3:0], feedback}; // shift toward msb
	end

	assign keying_bit = lfsr[0];

endmodule

/* logic/dds_waveform_gen.sv */
`timescale 1ns/100ps

module dds_waveform_gen
	import dds_pkg::*;
(
	input  logic   CLK_25MHZ,
	input  logic   reset_from_key,
	input  phase_t phase_inc,
	output waves_t waves
);

	phase_t     phase;
	logic [7:0] addr_sin;
	logic [7:0] addr_cos;

	// quarter table lookup
	// bit 6 mirrors the address inside a half wave
	// bit 7 selects the negative half
	function automatic sample_t sine_lookup(input logic [7:0] addr);
		logic [5:0]  idx;
		logic [10:0] mag;
		sample_t     pos;
		idx = addr[6] ? ~addr[5:0] : addr[5:0];
		mag = sine_quarter[idx];
		pos = sample_t'({1'b0, mag});
		return addr[7] ? -pos : pos;
	endfunction

	////////////////////////////////////////////////////////////
	// phase accumulator
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			phase <= '0;
		else
			phase <= phase + phase_inc; // wraps mod 2^32
	end

	assign addr_sin = phase[31:24];
	assign addr_cos = addr_sin + 8'd64; // a quarter turn ahead

	////////////////////////////////////////////////////////////
	// waveform registers, one cycle behind the phase
	////////////////////////////////////////////////////////////
	always_ff @(posedge CLK_25MHZ)
	begin
		waves.sine <= sine_lookup(addr_sin);
		waves.cosine <= sine_lookup(addr_cos);

		// full scale square from the top phase bit
		if (phase[31])
			waves.square <= SAMPLE_MIN;
		else
			waves.square <= SAMPLE_MAX;

		waves.saw <= sample_t'(phase[31:20]); // ramps -2048 to 2047 across a turn
	end

endmodule

/* logic/modulation_mux.sv */
`timescale 1ns/100ps

module modulation_mux
	import dds_pkg::*;
(
	input  logic      CLK_25MHZ,
	input  logic      reset_from_key,
	input  waves_t    carrier,
	input  waves_t    fsk,
	input  logic      keying_bit,
	input  wave_sel_e wave_sel,
	input  mod_sel_e  mod_sel,
	output sample_t   sample_out
);

	waves_t  source;
	sample_t picked;
	sample_t modulated;

	function automatic sample_t pick_wave(input waves_t w, input wave_sel_e sel);
		case (sel)
			SINE:    return w.sine;
			COSINE:  return w.cosine;
			SQUARE:  return w.square;
			default: return w.saw;
		endcase
	endfunction

	// -2048 has no positive twin, clamp it
	function automatic sample_t negate_sat(input sample_t s);
		if (s == SAMPLE_MIN)
			return SAMPLE_MAX;
		return -s;
	endfunction

	////////////////////////////////////////////////////////////
	// source pick and keying
	////////////////////////////////////////////////////////////
	assign source = (mod_sel == FSK) ? fsk : carrier; // fsk has its own generator
	assign picked = pick_wave(source, wave_sel);

	always_comb
	begin
		modulated = picked;
		case (mod_sel)
			ASK:
			begin
				if (!keying_bit)
					modulated = '0; // carrier off
			end
			BPSK:
			begin
				if (!keying_bit)
					modulated = negate_sat(picked); // half turn phase flip
			end
			default:
				modulated = picked;
		endcase
	end

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
			sample_out <= '0;
		else
			sample_out <= modulated;
	end

endmodule

/* logic/key_hold_tracker.sv */
`timescale 1ns/100ps

module key_hold_tracker
	import dds_pkg::*;
(
	input  logic       CLK_25MHZ,
	input  logic       reset_from_key,
	input  key_event_t key_event,
	output held_keys_t held_keys,
	output wave_sel_e  wave_sel,
	output mod_sel_e   mod_sel
);

	localparam logic [3:0] SLOT_NONE = 4'd15; // code not tracked

	logic [3:0] slot;
	logic       is_break;
	logic       is_make;

	// make code to held_keys bit
	function automatic logic [3:0] key_slot(input scan_event_t make);
		case (make)
			SC_KEY_1:       return 4'd0;
			SC_KEY_2:       return 4'd1;
			SC_KEY_3:       return 4'd2;
			SC_KEY_4:       return 4'd3;
			SC_KEY_5:       return 4'd4;
			SC_KEY_6:       return 4'd5;
			SC_KEY_7:       return 4'd6;
			SC_KEY_8:       return 4'd7;
			SC_SPACE:       return 4'd8;
			SC_N:           return 4'd9;
			SC_M:           return 4'd10;
			SC_ARROW_LEFT:  return 4'd11;
			SC_ARROW_RIGHT: return 4'd12;
			SC_ARROW_UP:    return 4'd13;
			SC_ARROW_DOWN:  return 4'd14;
			default:        return SLOT_NONE;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// event decode
	////////////////////////////////////////////////////////////
	assign is_break = key_event.code[7];
	assign is_make = !is_break;
	assign slot = key_slot({1'b0, key_event.code[6:0]}); // break maps onto its make

	always_ff @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			held_keys <= '0;
			wave_sel <= SINE;
			mod_sel <= NONE;
		end
		else if (key_event.valid && (slot != SLOT_NONE))
		begin
			held_keys[slot] <= is_make;

			// keys 1 to 4 pick the waveform, 5 to 8 the modulation
			if (is_make && (slot < 4'd4))
				wave_sel <= wave_sel_e'(slot[1:0]);
			else if (is_make && (slot < 4'd8))
				mod_sel <= mod_sel_e'(slot[1:0]);
		end
	end

endmodule

/* logic/dds_modulation_top.sv */
`timescale 1ns/100ps

module dds_modulation_top
	import dds_pkg::*;
#(
	parameter int     TICK_DIV = 25_000_000,  // one keying step per second
	parameter phase_t FSK_INC_MARK = 32'd171798692,  // about 1 mhz
	parameter phase_t FSK_INC_SPACE = 32'd42949673   // about 250 khz
)
(
	input  logic       CLK_25MHZ,
	input  logic       reset_from_key,
	input  key_event_t key_event,
	output sample_t    sample_out,
	output logic       keying_bit,
	output held_keys_t held_keys,
	output wave_sel_e  wave_sel,
	output mod_sel_e   mod_sel
);

	phase_t fsk_inc;
	waves_t carrier_waves;
	waves_t fsk_waves;

	////////////////////////////////////////////////////////////
	// control side
	////////////////////////////////////////////////////////////
	key_hold_tracker i_key_hold_tracker (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.key_event      (key_event),
		.held_keys      (held_keys),
		.wave_sel       (wave_sel),
		.mod_sel        (mod_sel)
	);

	keying_bit_source #(.TICK_DIV(TICK_DIV)) i_keying_bit_source (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.keying_bit     (keying_bit)
	);

	////////////////////////////////////////////////////////////
	// signal side
	////////////////////////////////////////////////////////////
	assign fsk_inc = keying_bit ? FSK_INC_MARK : FSK_INC_SPACE; // applied the same cycle

	dds_waveform_gen i_carrier_gen (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.phase_inc      (DDS_CARRIER_INC),
		.waves          (carrier_waves)
	);

	dds_waveform_gen i_fsk_gen (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.phase_inc      (fsk_inc),
		.waves          (fsk_waves)
	);

	modulation_mux i_modulation_mux (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.carrier        (carrier_waves),
		.fsk            (fsk_waves),
		.keying_bit     (keying_bit),
		.wave_sel       (wave_sel),
		.mod_sel        (mod_sel),
		.sample_out     (sample_out)
	);

endmodule

/* tb/dds_modulation_chk.sv */
`timescale 1ns/100ps

module dds_modulation_chk
	import dds_pkg::*;
(
	input logic       CLK_25MHZ,
	input logic       reset_from_key,
	input logic       key_valid,
	input logic [1:0] wave_sel,
	input logic [1:0] mod_sel,
	input held_keys_t held_keys,
	input logic       tick,
	input logic       keying_bit
);

	int unsigned fail_count = 0;

	////////////////////////////////////////////////////////////
	// tracker side
	////////////////////////////////////////////////////////////
	sel_after_event: assert property (
		@(posedge CLK_25MHZ) disable iff (reset_from_key)
		($changed(wave_sel) || $changed(mod_sel)) |-> $past(key_valid)
	)
	else
	begin
		$error("wave_sel or mod_sel changed without a key event the cycle before");
		fail_count++;
	end

	held_clear_in_reset: assert property (
		@(posedge CLK_25MHZ) reset_from_key |=> (held_keys == '0)
	)
	else
	begin
		$error("held_keys not zero while reset is applied");
		fail_count++;
	end

	// keying bit only moves after a divider tick
	bit_after_tick: assert property (
		@(posedge CLK_25MHZ) disable iff (reset_from_key)
		$changed(keying_bit) |-> $past(tick)
	)
	else
	begin
		$error("keying_bit changed without a tick the cycle before");
		fail_count++;
	end

endmodule

bind key_hold_tracker dds_modulation_chk i_tracker_chk (
	.CLK_25MHZ      (CLK_25MHZ),
	.reset_from_key (reset_from_key),
	.key_valid      (key_event.valid),
	.wave_sel       (wave_sel),
	.mod_sel        (mod_sel),
	.held_keys      (held_keys),
	.tick           (1'b0),
	.keying_bit     (1'b0)
);

bind keying_bit_source dds_modulation_chk i_keying_chk (
	.CLK_25MHZ      (CLK_25MHZ),
	.reset_from_key (reset_from_key),
	.key_valid      (1'b0),
	.wave_sel       (2'b00),
	.mod_sel        (2'b00),
	.held_keys      ('0),
	.tick           (tick),
	.keying_bit     (keying_bit)
);

/* tb/tb_dds_modulation.sv */
`timescale 1ns/100ps

module tb_dds_modulation
	import dds_pkg::*;
();

	localparam int TICK_DIV = 16;
	localparam phase_t INC_MARK = 32'h1000_0000;  // 1/16 turn per cycle
	localparam phase_t INC_SPACE = 32'h0400_0000; // 1/64 turn per cycle

	typedef struct packed {
		scan_event_t code;
		logic [15:0] idle;
		held_keys_t  held;
		wave_sel_e   wave;
		mod_sel_e    mod;
	} stim_row_t;

	// event and dwell plus the expected tracker outputs one cycle after the strobe
	localparam stim_row_t STIM_TABLE [14] = '{
		'{8'h1C,            16'd2,   15'h0000, SINE,   NONE},  // untracked make
		'{8'h9C,            16'd2,   15'h0000, SINE,   NONE},  // untracked break
		'{SC_KEY_2,         16'd40,  15'h0002, COSINE, NONE},
		'{SC_KEY_2 | 8'h80, 16'd2,   15'h0000, COSINE, NONE},
		'{SC_KEY_3,         16'd40,  15'h0004, SQUARE, NONE},
		'{SC_KEY_4,         16'd40,  15'h000C, SAW,    NONE},
		'{SC_KEY_3 | 8'h80, 16'd2,   15'h0008, SAW,    NONE},
		'{SC_KEY_1,         16'd40,  15'h0009, SINE,   NONE},
		'{SC_KEY_6,         16'd200, 15'h0029, SINE,   ASK},
		'{SC_KEY_7,         16'd200, 15'h0069, SINE,   BPSK},
		'{SC_KEY_4 | 8'h80, 16'd2,   15'h0061, SINE,   BPSK},
		'{SC_KEY_4,         16'd200, 15'h0069, SAW,    BPSK},
		'{SC_KEY_8,         16'd200, 15'h00E9, SAW,    FSK},
		'{SC_KEY_5,         16'd2,   15'h00F9, SAW,    NONE}
	};

	// held_keys bit order
	localparam scan_event_t KEY_CODES [15] = '{
		SC_KEY_1, SC_KEY_2, SC_KEY_3, SC_KEY_4, SC_KEY_5, SC_KEY_6, SC_KEY_7, SC_KEY_8,
		SC_SPACE, SC_N, SC_M, SC_ARROW_LEFT, SC_ARROW_RIGHT, SC_ARROW_UP, SC_ARROW_DOWN
	};

	logic        CLK_25MHZ;
	logic        reset_from_key;
	key_event_t  key_event;
	sample_t     sample_out;
	logic        keying_bit;
	held_keys_t  held_keys;
	wave_sel_e   wave_sel;
	mod_sel_e    mod_sel;

	// reference model state
	phase_t      m_phase_car;
	phase_t      m_phase_fsk;
	waves_t      m_car;
	waves_t      m_fsk;
	lfsr_t       m_lfsr;
	int          m_div;
	sample_t     m_sample;
	wave_sel_e   m_wave;
	mod_sel_e    m_mod;
	held_keys_t  exp_held;
	logic        check_en;
	int unsigned lcg_state;

	dds_modulation_top #(
		.TICK_DIV      (TICK_DIV),
		.FSK_INC_MARK  (INC_MARK),
		.FSK_INC_SPACE (INC_SPACE)
	) i_dds_modulation_top (
		.CLK_25MHZ      (CLK_25MHZ),
		.reset_from_key (reset_from_key),
		.key_event      (key_event),
		.sample_out     (sample_out),
		.keying_bit     (keying_bit),
		.held_keys      (held_keys),
		.wave_sel       (wave_sel),
		.mod_sel        (mod_sel)
	);

	always #20 CLK_25MHZ = ~CLK_25MHZ;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic sample_t sine_of(input logic [7:0] addr);
		int idx;
		int mag;
		idx = addr[6] ? 63 - addr[5:0] : addr[5:0]; // second quarter runs backwards
		mag = sine_quarter[idx];
		return addr[7] ? sample_t'(-mag) : sample_t'(mag);
	endfunction

	function automatic waves_t waves_of(input phase_t p);
		waves_t w;
		w.sine = sine_of(p[31:24]);
		w.cosine = sine_of(p[31:24] + 8'd64);
		w.square = p[31] ? SAMPLE_MIN : SAMPLE_MAX;
		w.saw = sample_t'(p[31:20]);
		return w;
	endfunction

	function automatic sample_t expected_sample(input waves_t car, input waves_t fsk,
		input logic kbit, input wave_sel_e wave, input mod_sel_e mod);
		waves_t  src;
		sample_t s;
		src = (mod == FSK) ? fsk : car;
		case (wave)
			SINE:    s = src.sine;
			COSINE:  s = src.cosine;
			SQUARE:  s = src.square;
			default: s = src.saw;
		endcase
		if (mod == ASK && !kbit)
			s = '0;
		else if (mod == BPSK && !kbit)
			s = (s == SAMPLE_MIN) ? SAMPLE_MAX : -s;
		return s;
	endfunction

	always @(posedge CLK_25MHZ)
	begin
		if (reset_from_key)
		begin
			m_phase_car = '0;
			m_phase_fsk = '0;
			m_car = waves_of('0);
			m_fsk = waves_of('0);
			m_lfsr = LFSR_SEED;
			m_div = 0;
			m_sample = '0;
		end
		else
		begin
			// output stage first so it sees last cycle's waves
			m_sample = expected_sample(m_car, m_fsk, m_lfsr[0], m_wave, m_mod);
			m_car = waves_of(m_phase_car);
			m_fsk = waves_of(m_phase_fsk);
			m_phase_car = m_phase_car + DDS_CARRIER_INC;
			m_phase_fsk = m_phase_fsk + (m_lfsr[0] ? INC_MARK : INC_SPACE);
			if (m_div == TICK_DIV - 1)
			begin
				m_div = 0;
				m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
			end
			else
				m_div++;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("[FAIL] %0t ns %s", $time, msg));
	endtask

	// failed assertions in the bound checkers
	function automatic int unsigned bound_failures();
		return i_dds_modulation_top.i_key_hold_tracker.i_tracker_chk.fail_count
			+ i_dds_modulation_top.i_keying_bit_source.i_keying_chk.fail_count;
	endfunction

	always @(negedge CLK_25MHZ)
	begin
		assert (bound_failures() == 0)
		else abort_run("a bound assertion on the tracker or the keying bit source failed");
		if (check_en)
		begin
			assert (sample_out === m_sample)
			else report_mismatch($sformatf("sample_out %0d, model %0d (%s, %s)",
				sample_out, m_sample, m_wave.name(), m_mod.name()));
			assert (keying_bit === m_lfsr[0])
			else report_mismatch($sformatf("keying_bit %b, model %b", keying_bit, m_lfsr[0]));
		end
	end

	task automatic apply_event(input scan_event_t code, input int idle,
		input held_keys_t held_exp, input wave_sel_e wave_exp, input mod_sel_e mod_exp);
		@(posedge CLK_25MHZ);
		key_event <= {1'b1, code};
		@(negedge CLK_25MHZ);
		assert (held_keys === exp_held)
		else report_mismatch($sformatf("held_keys moved before event %h was taken", code));
		@(posedge CLK_25MHZ);
		key_event <= {1'b0, 8'h00};
		@(negedge CLK_25MHZ);
		assert (held_keys === held_exp)
		else report_mismatch($sformatf("event %h: held_keys %h, expected %h",
			code, held_keys, held_exp));
		assert (wave_sel === wave_exp && mod_sel === mod_exp)
		else report_mismatch($sformatf("event %h: selection %s/%s, expected %s/%s",
			code, wave_sel.name(), mod_sel.name(), wave_exp.name(), mod_exp.name()));
		exp_held = held_exp;
		m_wave = wave_exp;
		m_mod = mod_exp;
		repeat (idle) @(posedge CLK_25MHZ);
	endtask

	// expected outputs from the key rules before the event itself
	task automatic press(input int k, input logic make, input int idle);
		held_keys_t h;
		wave_sel_e  w;
		mod_sel_e   m;
		h = exp_held;
		w = m_wave;
		m = m_mod;
		h[k] = make;
		if (make && k < 4)
			w = wave_sel_e'(k);
		else if (make && k < 8)
			m = mod_sel_e'(k - 4);
		apply_event(make ? KEY_CODES[k] : (KEY_CODES[k] | 8'h80), idle, h, w, m);
	endtask

	// one sample per tick over two m-sequence periods of 31 steps
	task automatic check_keying_sequence();
		logic bits [62];
		logic start;
		int   waited;
		int   ones;
		int   i;
		start = keying_bit;
		waited = 0;
		ones = 0;
		while (keying_bit === start)
		begin
			@(negedge CLK_25MHZ);
			waited++;
			if (waited > 6 * TICK_DIV)
				abort_run("timed out waiting for the keying bit to change");
		end
		for (i = 0; i < 62; i++)
		begin
			bits[i] = keying_bit;
			repeat (TICK_DIV) @(negedge CLK_25MHZ);
		end
		for (i = 0; i < 31; i++)
		begin
			assert (bits[i] === bits[i + 31])
			else report_mismatch($sformatf("keying step %0d differs one period later", i));
			ones += bits[i];
		end
		assert (ones == 16)
		else report_mismatch($sformatf("%0d ones in a 31 step period, expected 16", ones));
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		int k;
		int n;
		CLK_25MHZ = 1'b0;
		reset_from_key = 1'b1;
		key_event = '0;
		check_en = 1'b0;
		exp_held = '0;
		m_wave = SINE;
		m_mod = NONE;
		lcg_state = 32'd59438;

		repeat (15) @(posedge CLK_25MHZ);
		@(negedge CLK_25MHZ);
		assert (sample_out === 12'sd0 && keying_bit === 1'b1)
		else report_mismatch("sample_out or keying_bit not at reset value");
		assert (held_keys === '0 && wave_sel === SINE && mod_sel === NONE)
		else report_mismatch("tracker outputs not at reset value");
		@(posedge CLK_25MHZ); // 16th edge in reset
		reset_from_key <= 1'b0;
		check_en = 1'b1;

		for (n = 0; n < 14; n++)
			apply_event(STIM_TABLE[n].code, STIM_TABLE[n].idle, STIM_TABLE[n].held,
				STIM_TABLE[n].wave, STIM_TABLE[n].mod);

		for (k = 0; k < 15; k++)
		begin
			press(k, 1'b1, 1);
			press(k, 1'b0, 1);
		end

		// random digit keys and dwell times
		for (n = 0; n < 16; n++)
		begin
			k = lcg_next() % 8;
			press(k, 1'b1, 4 + lcg_next() % 60);
			press(k, 1'b0, 2);
		end

		check_keying_sequence();
		if (bound_failures() != 0)
			abort_run("a bound assertion on the tracker or the keying bit source failed");
		else
		begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* vlog.f */
logic/dds_pkg.sv
logic/keying_bit_source.sv
logic/dds_waveform_gen.sv
logic/modulation_mux.sv
logic/key_hold_tracker.sv
logic/dds_modulation_top.sv
tb/dds_modulation_chk.sv
tb/tb_dds_modulation.sv

/* Bender.yml */
package:
  name: dds_modulation

sources:
  # design, package first
  - logic/dds_pkg.sv
  - logic/keying_bit_source.sv
  - logic/dds_waveform_gen.sv
  - logic/modulation_mux.sv
  - logic/key_hold_tracker.sv
  - logic/dds_modulation_top.sv

  # bound checks and testbench top tb_dds_modulation
  - target: test
    files:
      - tb/dds_modulation_chk.sv
      - tb/tb_dds_modulation.sv
